// File: mem_pkg.sv
package mem_pkg;

    // data memory geometry
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);   // word address bits

    // register file index width
    localparam int REG_AW = 5;

    // kind of work the memory stage does for an instruction
    typedef enum logic [1:0] {
        OP_NONE  = 2'b00,   // reg-to-reg result, no memory access
        OP_LOAD  = 2'b01,   // memory to register
        OP_STORE = 2'b10    // register to memory
    } access_op_e;

    // access width
    typedef enum logic [1:0] {
        SZ_BYTE = 2'b00,
        SZ_HALF = 2'b01,
        SZ_WORD = 2'b10
    } access_sz_e;

endpackage

// File: ex_mem_reg.sv
`timescale 1ns/100ps

module ex_mem_reg import mem_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              flush_i,

    input  access_op_e        op_i,
    input  access_sz_e        sz_i,
    input  logic              unsigned_i,
    input  logic [31:0]       addr_i,
    input  logic [31:0]       data_i,
    input  logic [REG_AW-1:0] reg_addr_i,

    output access_op_e        op_o,
    output access_sz_e        sz_o,
    output logic              unsigned_o,
    output logic [31:0]       addr_o,
    output logic [31:0]       data_o,
    output logic [REG_AW-1:0] reg_addr_o
);

    // control fields, killed by reset or exception flush
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            op_o       <= OP_NONE;     // bubble
            reg_addr_o <= '0;          // r0 never written back
        end else begin
            op_o       <= op_i;
            reg_addr_o <= reg_addr_i;
        end
    end

    // payload
    always_ff @(posedge clk_i) begin
        sz_o       <= sz_i;
        unsigned_o <= unsigned_i;
        addr_o     <= addr_i;
        data_o     <= data_i;
    end

endmodule

// File: mem_access.sv
`timescale 1ns/100ps

module mem_access import mem_pkg::*; (
    input  access_op_e         op_i,
    input  access_sz_e         sz_i,
    input  logic               unsigned_i,
    input  logic [31:0]        addr_i,
    input  logic [31:0]        data_i,
    input  logic [REG_AW-1:0]  reg_addr_i,
    input  logic [31:0]        mem_rdata_i,

    output logic [DMEM_AW-1:0] mem_addr_o,
    output logic [31:0]        mem_wdata_o,
    output logic [3:0]         mem_be_o,
    output logic               mem_rd_o,
    output logic               mem_wr_o,
    output logic [31:0]        result_o,
    output logic               reg_wr_o,
    output logic               align_err_o
);

    logic        is_mem;
    logic        misaligned;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    // both loads and stores are checked for alignment
    assign is_mem     = (op_i == OP_LOAD) || (op_i == OP_STORE);
    assign misaligned = is_mem &&
                        ((sz_i == SZ_HALF && addr_i[0]) ||
                         (sz_i == SZ_WORD && addr_i[1:0] != 2'b00));

    assign align_err_o = misaligned;
    assign mem_addr_o  = addr_i[DMEM_AW+1:2];   // word index

    // a misaligned access drops its own strobe
    assign mem_rd_o = (op_i == OP_LOAD) && !misaligned;
    assign mem_wr_o = (op_i == OP_STORE) && !misaligned;

    // stores never write back, nor does r0
    assign reg_wr_o = (op_i == OP_LOAD || op_i == OP_NONE) && !misaligned &&
                      (reg_addr_i != '0);

    // byte lanes
    always_comb begin
        case (sz_i)
            SZ_BYTE: begin
                mem_be_o = 4'b0001 << addr_i[1:0];
            end
            SZ_HALF: begin
                mem_be_o = addr_i[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                mem_be_o = 4'b1111;
            end
        endcase
    end

    // store data replicated over all lanes, the enables pick the right one
    always_comb begin
        case (sz_i)
            SZ_BYTE: begin
                mem_wdata_o = {4{data_i[7:0]}};
            end
            SZ_HALF: begin
                mem_wdata_o = {2{data_i[15:0]}};
            end
            default: begin
                mem_wdata_o = data_i;
            end
        endcase
    end

    // load lane select
    always_comb begin
        ld_half = addr_i[1] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];
        case (addr_i[1:0])
            2'b00:   ld_byte = mem_rdata_i[7:0];
            2'b01:   ld_byte = mem_rdata_i[15:8];
            2'b10:   ld_byte = mem_rdata_i[23:16];
            default: ld_byte = mem_rdata_i[31:24];
        endcase
    end

    // result with sign or zero extension
    always_comb begin
        if (op_i == OP_LOAD) begin
            case (sz_i)
                SZ_BYTE: begin
                    result_o = unsigned_i ? {24'b0, ld_byte} :
                                            {{24{ld_byte[7]}}, ld_byte};
                end
                SZ_HALF: begin
                    result_o = unsigned_i ? {16'b0, ld_half} :
                                            {{16{ld_half[15]}}, ld_half};
                end
                default: begin
                    result_o = mem_rdata_i;
                end
            endcase
        end else begin
            result_o = data_i;  // alu result passes through
        end
    end

endmodule

// File: data_ram.sv
`timescale 1ns/100ps

module data_ram import mem_pkg::*; (
    input  logic               clk_i,
    input  logic [DMEM_AW-1:0] addr_i,
    input  logic [31:0]        wdata_i,
    input  logic [3:0]         be_i,
    input  logic               wr_i,
    output logic [31:0]        rdata_o
);

    logic [31:0] mem [DMEM_WORDS];

    // async read, a store is visible the cycle after its edge
    assign rdata_o = mem[addr_i];

    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            for (int i = 0; i < 4; i++) begin
                if (be_i[i]) begin
                    mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
                end
            end
        end
    end

    // a write with no lane enabled means the access block lost its size
    a_be_on_write: assert property (
        @(posedge clk_i) wr_i |-> (be_i != 4'b0000)
    );

endmodule

// File: mem_wb_reg.sv
`timescale 1ns/100ps

module mem_wb_reg import mem_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,

    input  logic [31:0]       result_i,
    input  logic [REG_AW-1:0] reg_addr_i,
    input  logic              reg_wr_i,
    input  logic              align_err_i,

    output logic [31:0]       wb_data_o,
    output logic [REG_AW-1:0] wb_reg_addr_o,
    output logic              wb_reg_wr_o,
    output logic              align_err_o
);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_reg_wr_o <= 1'b0;
            align_err_o <= 1'b0;
        end else begin
            wb_reg_wr_o <= reg_wr_i;
            align_err_o <= align_err_i;
        end
    end

    // result and destination, no reset needed
    always_ff @(posedge clk_i) begin
        wb_data_o     <= result_i;
        wb_reg_addr_o <= reg_addr_i;
    end

    // writeback and fault are exclusive, and r0 is never a target
    a_wb_legal: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        wb_reg_wr_o |-> (!align_err_o && wb_reg_addr_o != '0)
    );

endmodule

// File: mem_stage_top.sv
`timescale 1ns/100ps

module mem_stage_top import mem_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              flush_i,

    input  access_op_e        ex_op_i,
    input  access_sz_e        ex_sz_i,
    input  logic              ex_unsigned_i,
    input  logic [31:0]       ex_addr_i,
    input  logic [31:0]       ex_data_i,
    input  logic [REG_AW-1:0] ex_reg_addr_i,

    output logic [31:0]       wb_data_o,
    output logic [REG_AW-1:0] wb_reg_addr_o,
    output logic              wb_reg_wr_o,
    output logic              align_err_o
);

    // ex/mem register outputs
    access_op_e        m_op;
    access_sz_e        m_sz;
    logic              m_unsigned;
    logic [31:0]       m_addr;
    logic [31:0]       m_data;
    logic [REG_AW-1:0] m_reg_addr;

    // ram side
    logic [DMEM_AW-1:0] mem_addr;
    logic [31:0]        mem_wdata;
    logic [31:0]        mem_rdata;
    logic [3:0]         mem_be;
    logic               mem_wr;

    // toward mem/wb
    logic [31:0] m_result;
    logic        m_reg_wr;
    logic        m_align_err;

    ex_mem_reg u_ex_mem_reg (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .op_i       (ex_op_i),
        .sz_i       (ex_sz_i),
        .unsigned_i (ex_unsigned_i),
        .addr_i     (ex_addr_i),
        .data_i     (ex_data_i),
        .reg_addr_i (ex_reg_addr_i),
        .op_o       (m_op),
        .sz_o       (m_sz),
        .unsigned_o (m_unsigned),
        .addr_o     (m_addr),
        .data_o     (m_data),
        .reg_addr_o (m_reg_addr)
    );

    mem_access u_mem_access (
        .op_i        (m_op),
        .sz_i        (m_sz),
        .unsigned_i  (m_unsigned),
        .addr_i      (m_addr),
        .data_i      (m_data),
        .reg_addr_i  (m_reg_addr),
        .mem_rdata_i (mem_rdata),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_be_o    (mem_be),
        .mem_rd_o    (),           // ram reads combinationally
        .mem_wr_o    (mem_wr),
        .result_o    (m_result),
        .reg_wr_o    (m_reg_wr),
        .align_err_o (m_align_err)
    );

    data_ram u_data_ram (
        .clk_i   (clk_i),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .be_i    (mem_be),
        .wr_i    (mem_wr),
        .rdata_o (mem_rdata)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .result_i      (m_result),
        .reg_addr_i    (m_reg_addr),
        .reg_wr_i      (m_reg_wr),
        .align_err_i   (m_align_err),
        .wb_data_o     (wb_data_o),
        .wb_reg_addr_o (wb_reg_addr_o),
        .wb_reg_wr_o   (wb_reg_wr_o),
        .align_err_o   (align_err_o)
    );

endmodule

// File: tb_mem_stage.sv
`timescale 1ns/100ps

module tb_mem_stage import mem_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int TEST_CYCLES = 274 + 20 + 28 + 44 + 9 + 6;   // per test, in issue order
    localparam int MARGIN      = 60;

    typedef struct packed {
        logic              wr;
        logic              err;
        logic [REG_AW-1:0] rd;
        logic [31:0]       data;
    } expect_t;

    logic              clk_i = 1'b0;
    logic              rst_n_i;
    logic              flush_i;
    access_op_e        ex_op_i;
    access_sz_e        ex_sz_i;
    logic              ex_unsigned_i;
    logic [31:0]       ex_addr_i;
    logic [31:0]       ex_data_i;
    logic [REG_AW-1:0] ex_reg_addr_i;
    logic [31:0]       wb_data_o;
    logic [REG_AW-1:0] wb_reg_addr_o;
    logic              wb_reg_wr_o;
    logic              align_err_o;

    logic [31:0] model [DMEM_WORDS];   // byte-lane memory model
    expect_t     exp_q [$];            // one entry per issued slot
    logic [31:0] lfsr = 32'hf52d;
    int          err_cnt = 0;
    int          check_cnt = 0;
    int          test_err_base = 0;

    mem_stage_top uut (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // drive one slot, then check the slot issued two edges earlier
    task automatic issue_op(input access_op_e op, input access_sz_e sz, input logic uns,
                            input logic [31:0] addr, input logic [31:0] data,
                            input logic [REG_AW-1:0] rd, input logic fl);
        expect_t            e;
        logic [DMEM_AW-1:0] w;
        logic               mis;
        logic [31:0]        raw;
        w   = addr[DMEM_AW+1:2];
        mis = (op != OP_NONE) &&
              ((sz == SZ_HALF && addr[0]) || (sz == SZ_WORD && addr[1:0] != 2'b00));
        e.err  = mis && !fl;
        e.wr   = !fl && !mis && (op != OP_STORE) && (rd != '0);
        e.rd   = rd;
        e.data = data;
        if (op == OP_STORE && !mis && !fl) begin
            case (sz)
                SZ_BYTE: model[w][{addr[1:0], 3'b000} +: 8] = data[7:0];
                SZ_HALF: model[w][{addr[1], 4'b0000} +: 16] = data[15:0];
                default: model[w] = data;
            endcase
        end
        if (op == OP_LOAD) begin
            raw = model[w] >> {addr[1:0], 3'b000};
            case (sz)
                SZ_BYTE: e.data = uns ? {24'b0, raw[7:0]} : {{24{raw[7]}}, raw[7:0]};
                SZ_HALF: e.data = uns ? {16'b0, raw[15:0]} : {{16{raw[15]}}, raw[15:0]};
                default: e.data = model[w];
            endcase
        end
        @(posedge clk_i);
        ex_op_i       <= op;
        ex_sz_i       <= sz;
        ex_unsigned_i <= uns;
        ex_addr_i     <= addr;
        ex_data_i     <= data;
        ex_reg_addr_i <= rd;
        flush_i       <= fl;
        exp_q.push_back(e);
        @(negedge clk_i);
        if (exp_q.size() == 3) begin
            e = exp_q.pop_front();
            compare("wb_reg_wr_o", 32'(wb_reg_wr_o), 32'(e.wr));
            compare("align_err_o", 32'(align_err_o), 32'(e.err));
            if (e.wr) begin
                compare("wb_data_o", wb_data_o, e.data);
                compare("wb_reg_addr_o", 32'(wb_reg_addr_o), 32'(e.rd));
            end
        end
    endtask

    task automatic end_test(input string name);
        repeat (2) issue_op(OP_NONE, SZ_WORD, 1'b0, 32'h0, 32'h0, '0, 1'b0);   // drain
        $display("%s done, %0d errors", name, err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    task automatic word_store_load();
        logic [31:0]       a;
        logic [31:0]       d;
        logic [REG_AW-1:0] rd;
        for (int w = 0; w < DMEM_WORDS; w++) begin
            d = lfsr_bits(32);
            issue_op(OP_STORE, SZ_WORD, 1'b0, 32'(w) << 2, d, REG_AW'(1), 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            a  = lfsr_bits(DMEM_AW + 2) & ~32'h3;
            d  = lfsr_bits(32);
            rd = REG_AW'(lfsr_bits(REG_AW)) | REG_AW'(1);
            issue_op(OP_STORE, SZ_WORD, 1'b0, a, d, rd, 1'b0);
            issue_op(OP_LOAD, SZ_WORD, 1'b0, a, 32'h0, rd, 1'b0);
        end
        end_test("word store/load");
    endtask

    task automatic partial_store_merge();
        logic [31:0] a;
        logic [31:0] off;
        logic [31:0] d;
        for (int i = 0; i < 6; i++) begin
            a   = lfsr_bits(DMEM_AW + 2) & ~32'h3;
            off = lfsr_bits(2);
            d   = lfsr_bits(32);
            issue_op(OP_STORE, SZ_BYTE, 1'b0, a | off, d, '0, 1'b0);
            off = lfsr_bits(1) << 1;
            d   = lfsr_bits(32);
            issue_op(OP_STORE, SZ_HALF, 1'b0, a | off, d, '0, 1'b0);
            issue_op(OP_LOAD, SZ_WORD, 1'b0, a, 32'h0, REG_AW'(7), 1'b0);
        end
        end_test("partial store merge");
    endtask

    task automatic load_extension();
        logic [31:0] a;
        logic [31:0] pat [2];
        pat[0] = 32'h8a7b_c65d;   // lanes 1 and 3 negative
        pat[1] = 32'h7596_3aa2;   // lanes 0 and 2 negative
        for (int p = 0; p < 2; p++) begin
            a = lfsr_bits(DMEM_AW + 2) & ~32'h3;
            issue_op(OP_STORE, SZ_WORD, 1'b0, a, pat[p], '0, 1'b0);
            for (int u = 0; u < 2; u++) begin
                for (int off = 0; off < 4; off++) begin
                    issue_op(OP_LOAD, SZ_BYTE, 1'(u), a + 32'(off), 32'h0, REG_AW'(3), 1'b0);
                end
                issue_op(OP_LOAD, SZ_HALF, 1'(u), a, 32'h0, REG_AW'(3), 1'b0);
                issue_op(OP_LOAD, SZ_HALF, 1'(u), a + 32'd2, 32'h0, REG_AW'(3), 1'b0);
            end
        end
        end_test("load extension");
    endtask

    task automatic pass_through_stream();
        logic [31:0] r;
        access_op_e  op;
        access_sz_e  sz;
        issue_op(OP_NONE, SZ_WORD, 1'b0, 32'h0, lfsr_bits(32), '0, 1'b0);   // r0 never written
        issue_op(OP_NONE, SZ_WORD, 1'b0, 32'h0, lfsr_bits(32), REG_AW'(9), 1'b0);
        for (int i = 0; i < 40; i++) begin
            r  = lfsr_bits(2);
            op = (r == 0) ? OP_NONE : ((r == 1) ? OP_LOAD : OP_STORE);
            r  = lfsr_bits(2);
            sz = r[1] ? SZ_WORD : (r[0] ? SZ_HALF : SZ_BYTE);
            issue_op(op, sz, 1'(lfsr_bits(1)), lfsr_bits(DMEM_AW + 2), lfsr_bits(32),
                     REG_AW'(lfsr_bits(REG_AW)), 1'b0);
        end
        end_test("pass-through stream");
    endtask

    task automatic misaligned_access();
        logic [31:0] a;
        logic [31:0] d;
        a = lfsr_bits(DMEM_AW + 2) & ~32'h3;
        d = lfsr_bits(32);
        issue_op(OP_STORE, SZ_WORD, 1'b0, a, d, '0, 1'b0);
        issue_op(OP_STORE, SZ_HALF, 1'b0, a + 32'd1, ~d, '0, 1'b0);
        issue_op(OP_STORE, SZ_WORD, 1'b0, a + 32'd2, ~d, '0, 1'b0);
        issue_op(OP_LOAD, SZ_WORD, 1'b0, a, 32'h0, REG_AW'(4), 1'b0);
        issue_op(OP_LOAD, SZ_HALF, 1'b0, a + 32'd3, 32'h0, REG_AW'(4), 1'b0);
        issue_op(OP_LOAD, SZ_WORD, 1'b1, a + 32'd1, 32'h0, REG_AW'(4), 1'b0);
        issue_op(OP_STORE, SZ_WORD, 1'b0, a + 32'd3, ~d, '0, 1'b0);
        end_test("misaligned access");
    endtask

    task automatic flush_kill();
        logic [31:0] a;
        logic [31:0] d;
        a = lfsr_bits(DMEM_AW + 2) & ~32'h3;
        d = lfsr_bits(32);
        issue_op(OP_STORE, SZ_WORD, 1'b0, a, d, '0, 1'b0);
        issue_op(OP_STORE, SZ_WORD, 1'b0, a, ~d, '0, 1'b1);
        issue_op(OP_LOAD, SZ_WORD, 1'b0, a, 32'h0, REG_AW'(6), 1'b0);
        issue_op(OP_NONE, SZ_WORD, 1'b0, 32'h0, d, REG_AW'(6), 1'b1);
        end_test("flush kill");
    endtask

    initial begin
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        ex_op_i       = OP_NONE;
        ex_sz_i       = SZ_WORD;
        ex_unsigned_i = 1'b0;
        ex_addr_i     = 32'h0;
        ex_data_i     = 32'h0;
        ex_reg_addr_i = '0;
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;
        word_store_load();
        partial_store_merge();
        load_extension();
        pass_through_stream();
        misaligned_access();
        flush_kill();
        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
        $display("Timeout, the tests did not finish within %0d cycles", TEST_CYCLES + MARGIN);
        $display("Errors found");
        $finish;
    end

endmodule

// File: project.f
mem_pkg.sv
ex_mem_reg.sv
mem_access.sv
data_ram.sv
mem_wb_reg.sv
mem_stage_top.sv
tb_mem_stage.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_mem_stage -f project.f -o sim_mem_stage
./obj_dir/sim_mem_stage > sim.log 2>&1
cat sim.log
if grep -q "Errors found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"
